//--- rtl/cluster_periph_pkg.sv
/* Shared definitions for the cluster peripheral: bus and counter widths,
   the performance metric encoding, the register address map and the
   metric each counter tracks out of reset. */
package cluster_periph_pkg;

  localparam int unsigned RegWidth      = 32;
  localparam int unsigned AddrWidth     = 12;
  localparam int unsigned CounterWidth  = 48;
  localparam int unsigned DmaBytesWidth = 16;
  localparam int unsigned MetricWidth   = 5;
  localparam int unsigned HartWidth     = 8;

  // Event a performance counter accumulates.
  typedef enum logic [MetricWidth-1:0] {
    Cycle         = 5'd0,
    TcdmAccessed  = 5'd1,
    TcdmCongested = 5'd2,
    IssueFpu      = 5'd3,
    RetiredInstr  = 5'd4,
    RetiredLoad   = 5'd5,
    DmaBusy       = 5'd6,
    DmaBytes      = 5'd7,
    IcacheMiss    = 5'd8,
    IcacheHit     = 5'd9
  } perf_metric_e;

  // Byte offsets inside the peripheral window.
  localparam logic [AddrWidth-1:0] PerfCntEnOffset  = 12'h000;
  localparam logic [AddrWidth-1:0] PrefetchEnOffset = 12'h004;
  localparam logic [AddrWidth-1:0] ClintSetOffset   = 12'h008;
  localparam logic [AddrWidth-1:0] ClintClearOffset = 12'h00C;
  localparam logic [AddrWidth-1:0] PerfSelBase      = 12'h040;
  localparam logic [AddrWidth-1:0] PerfCntBase      = 12'h080;

  // Metric a counter is programmed with after reset.
  function automatic perf_metric_e ResetMetric(int unsigned idx);
    case (idx)
      0:       return Cycle;
      1:       return RetiredInstr;
      2:       return TcdmAccessed;
      3:       return IcacheMiss;
      4:       return IcacheHit;
      default: return Cycle;
    endcase
  endfunction

endpackage

//--- rtl/axil_reg_bridge.sv
/* AXI4-Lite slave that buffers one request per channel and turns it into a
   single-cycle register strobe. The register file answers in the strobe
   cycle; the answer is registered into the B or R channel. */
`timescale 1ns/100ps

module axil_reg_bridge (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic [cluster_periph_pkg::AddrWidth-1:0]  s_awaddr_i,
  input  logic                                      s_awvalid_i,
  output logic                                      s_awready_o,
  input  logic [cluster_periph_pkg::RegWidth-1:0]   s_wdata_i,
  input  logic [cluster_periph_pkg::RegWidth/8-1:0] s_wstrb_i,
  input  logic                                      s_wvalid_i,
  output logic                                      s_wready_o,
  output logic [1:0]                                s_bresp_o,
  output logic                                      s_bvalid_o,
  input  logic                                      s_bready_i,
  input  logic [cluster_periph_pkg::AddrWidth-1:0]  s_araddr_i,
  input  logic                                      s_arvalid_i,
  output logic                                      s_arready_o,
  output logic [cluster_periph_pkg::RegWidth-1:0]   s_rdata_o,
  output logic [1:0]                                s_rresp_o,
  output logic                                      s_rvalid_o,
  input  logic                                      s_rready_i,
  output logic                                      reg_wr_o,
  output logic                                      reg_rd_o,
  output logic [cluster_periph_pkg::AddrWidth-1:0]  reg_addr_o,
  output logic [cluster_periph_pkg::RegWidth-1:0]   reg_wdata_o,
  output logic [cluster_periph_pkg::RegWidth/8-1:0] reg_wstrb_o,
  input  logic [cluster_periph_pkg::RegWidth-1:0]   reg_rdata_i,
  input  logic                                      reg_err_i
);
  import cluster_periph_pkg::*;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  logic                   aw_full_q, w_full_q, ar_full_q;
  logic [AddrWidth-3:0]   aw_addr_q, ar_addr_q;
  logic [RegWidth-1:0]    w_data_q;
  logic [RegWidth/8-1:0]  w_strb_q;
  logic                   bvalid_q, rvalid_q;
  logic [1:0]             bresp_q, rresp_q;
  logic [RegWidth-1:0]    rdata_q;
  logic                   aw_hs, w_hs, ar_hs;
  logic                   wr_go, rd_go;

  assign s_awready_o = ~aw_full_q;
  assign s_wready_o  = ~w_full_q;
  assign s_arready_o = ~ar_full_q;

  assign aw_hs = s_awvalid_i & s_awready_o;
  assign w_hs  = s_wvalid_i & s_wready_o;
  assign ar_hs = s_arvalid_i & s_arready_o;

  // One strobe per cycle, writes first. A strobe needs its response slot free.
  assign wr_go = aw_full_q & w_full_q & ~bvalid_q;
  assign rd_go = ar_full_q & ~rvalid_q & ~wr_go;

  assign reg_wr_o    = wr_go;
  assign reg_rd_o    = rd_go;
  assign reg_addr_o  = {(wr_go ? aw_addr_q : ar_addr_q), 2'b00};
  assign reg_wdata_o = w_data_q;
  assign reg_wstrb_o = w_strb_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      ar_full_q <= 1'b0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // Holding registers empty as soon as their strobe has gone out.
      if (aw_hs) begin
        aw_full_q <= 1'b1;
      end else if (wr_go) begin
        aw_full_q <= 1'b0;
      end
      if (w_hs) begin
        w_full_q <= 1'b1;
      end else if (wr_go) begin
        w_full_q <= 1'b0;
      end
      if (ar_hs) begin
        ar_full_q <= 1'b1;
      end else if (rd_go) begin
        ar_full_q <= 1'b0;
      end
      if (wr_go) begin
        bvalid_q <= 1'b1;
      end else if (s_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_go) begin
        rvalid_q <= 1'b1;
      end else if (s_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) aw_addr_q <= s_awaddr_i[AddrWidth-1:2];
    if (ar_hs) ar_addr_q <= s_araddr_i[AddrWidth-1:2];
    if (w_hs) begin
      w_data_q <= s_wdata_i;
      w_strb_q <= s_wstrb_i;
    end
    if (wr_go) bresp_q <= reg_err_i ? RespSlvErr : RespOkay;
    if (rd_go) begin
      rdata_q <= reg_rdata_i;
      rresp_q <= reg_err_i ? RespSlvErr : RespOkay;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = rresp_q;

endmodule

//--- rtl/periph_regfile.sv
/* Register file of the cluster peripheral. Decodes the address map, holds
   the control, wake-up and counter selection registers, and returns read
   data and an error flag in the same cycle as the strobe. */
`timescale 1ns/100ps

module periph_regfile #(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        reg_wr_i,
  input  logic                                        reg_rd_i,
  input  logic [cluster_periph_pkg::AddrWidth-1:0]    reg_addr_i,
  input  logic [cluster_periph_pkg::RegWidth-1:0]     reg_wdata_i,
  input  logic [cluster_periph_pkg::RegWidth/8-1:0]   reg_wstrb_i,
  output logic [cluster_periph_pkg::RegWidth-1:0]     reg_rdata_o,
  output logic                                        reg_err_o,
  output logic                                        icache_prefetch_enable_o,
  output logic [NrCores-1:0]                          cl_clint_o,
  output logic [NumPerfCounters-1:0]                  cnt_en_o,
  output logic [NumPerfCounters-1:0]                  cnt_clear_o,
  output logic [NumPerfCounters*cluster_periph_pkg::MetricWidth-1:0] cnt_metric_o,
  output logic [NumPerfCounters*cluster_periph_pkg::HartWidth-1:0]   cnt_hart_o,
  input  logic [NumPerfCounters*cluster_periph_pkg::CounterWidth-1:0] cnt_value_i
);
  import cluster_periph_pkg::*;

  logic [AddrWidth-1:0]       addr;
  logic [RegWidth-1:0]        wmask;
  logic                       en_hit, pf_hit, set_hit, clr_hit;
  logic [NumPerfCounters-1:0] sel_hit, lo_hit, hi_hit;
  logic [NumPerfCounters-1:0] en_q;
  logic                       prefetch_q;
  logic [NrCores-1:0]         clint_q;
  perf_metric_e               metric_q [NumPerfCounters];
  logic [HartWidth-1:0]       hart_q [NumPerfCounters];

  assign addr    = {reg_addr_i[AddrWidth-1:2], 2'b00};
  assign en_hit  = addr == PerfCntEnOffset;
  assign pf_hit  = addr == PrefetchEnOffset;
  assign set_hit = addr == ClintSetOffset;
  assign clr_hit = addr == ClintClearOffset;

  // Byte strobes widened to a bit mask.
  always_comb begin
    for (int b = 0; b < RegWidth; b++) begin
      wmask[b] = reg_wstrb_i[b/8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q       <= '0;
      prefetch_q <= 1'b1;
      clint_q    <= '0;
    end else if (reg_wr_i) begin
      if (en_hit) begin
        en_q <= (en_q & ~wmask[NumPerfCounters-1:0]) |
                (reg_wdata_i[NumPerfCounters-1:0] & wmask[NumPerfCounters-1:0]);
      end
      if (pf_hit && reg_wstrb_i[0]) prefetch_q <= reg_wdata_i[0];
      // Set ORs the mask in, clear takes it out.
      if (set_hit) clint_q <= clint_q | (reg_wdata_i[NrCores-1:0] & wmask[NrCores-1:0]);
      if (clr_hit) clint_q <= clint_q & ~(reg_wdata_i[NrCores-1:0] & wmask[NrCores-1:0]);
    end
  end

  assign icache_prefetch_enable_o = prefetch_q;
  assign cl_clint_o               = clint_q;
  assign cnt_en_o                 = en_q;

  for (genvar i = 0; i < NumPerfCounters; i++) begin : gen_cnt
    localparam logic [AddrWidth-1:0] SelAddr = PerfSelBase + AddrWidth'(4 * i);
    localparam logic [AddrWidth-1:0] CntAddr = PerfCntBase + AddrWidth'(8 * i);

    assign sel_hit[i] = addr == SelAddr;
    assign lo_hit[i]  = addr == CntAddr;
    assign hi_hit[i]  = addr == (CntAddr + AddrWidth'(4));

    // Writing either counter word restarts the count.
    assign cnt_clear_o[i] = reg_wr_i & (lo_hit[i] | hi_hit[i]);

    assign cnt_metric_o[i*MetricWidth +: MetricWidth] = metric_q[i];
    assign cnt_hart_o[i*HartWidth +: HartWidth]       = hart_q[i];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        metric_q[i] <= ResetMetric(i);
        hart_q[i]   <= '0;
      end else if (reg_wr_i && sel_hit[i]) begin
        if (reg_wstrb_i[0]) metric_q[i] <= perf_metric_e'(reg_wdata_i[MetricWidth-1:0]);
        if (reg_wstrb_i[2]) hart_q[i] <= reg_wdata_i[16 +: HartWidth];
      end
    end
  end

  // Read data; unused bits and unmapped offsets return zero.
  always_comb begin
    reg_rdata_o = '0;
    if (en_hit) reg_rdata_o[NumPerfCounters-1:0] = en_q;
    if (pf_hit) reg_rdata_o[0] = prefetch_q;
    if (set_hit || clr_hit) reg_rdata_o[NrCores-1:0] = clint_q;
    for (int i = 0; i < NumPerfCounters; i++) begin
      if (sel_hit[i]) begin
        reg_rdata_o[MetricWidth-1:0]  = metric_q[i];
        reg_rdata_o[16 +: HartWidth] = hart_q[i];
      end
      if (lo_hit[i]) reg_rdata_o = cnt_value_i[i*CounterWidth +: RegWidth];
      if (hi_hit[i]) begin
        reg_rdata_o = RegWidth'(cnt_value_i[i*CounterWidth+RegWidth +: CounterWidth-RegWidth]);
      end
    end
  end

  assign reg_err_o = (reg_wr_i | reg_rd_i) &
                     ~(en_hit | pf_hit | set_hit | clr_hit |
                       (|sel_hit) | (|lo_hit) | (|hi_hit));

endmodule

//--- rtl/perf_counter_bank.sv
/* Bank of 48-bit performance counters. Event inputs pass one pipeline
   stage, then each counter picks the event named by its metric and hart
   select and adds it while enabled. */
`timescale 1ns/100ps

module perf_counter_bank #(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  logic [NumPerfCounters-1:0]                           cnt_en_i,
  input  logic [NumPerfCounters-1:0]                           cnt_clear_i,
  input  logic [NumPerfCounters*cluster_periph_pkg::MetricWidth-1:0] cnt_metric_i,
  input  logic [NumPerfCounters*cluster_periph_pkg::HartWidth-1:0]   cnt_hart_i,
  input  logic [NrCores-1:0]                                   core_retired_i,
  input  logic [NrCores-1:0]                                   core_load_i,
  input  logic [NrCores-1:0]                                   core_fpu_issue_i,
  input  logic                                                 tcdm_accessed_i,
  input  logic                                                 tcdm_congested_i,
  input  logic                                                 dma_busy_i,
  input  logic [cluster_periph_pkg::DmaBytesWidth-1:0]         dma_bytes_i,
  input  logic [NrCores-1:0]                                   icache_hit_i,
  input  logic [NrCores-1:0]                                   icache_miss_i,
  output logic [NumPerfCounters*cluster_periph_pkg::CounterWidth-1:0] cnt_value_o
);
  import cluster_periph_pkg::*;

  localparam int unsigned CoreSelWidth = $clog2(NrCores);

  logic [NrCores-1:0]       retired_q, load_q, fpu_q, hit_q, miss_q;
  logic                     accessed_q, congested_q, busy_q;
  logic [DmaBytesWidth-1:0] bytes_q;

  // Pipeline stage on all event inputs to ease timing.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retired_q   <= '0;
      load_q      <= '0;
      fpu_q       <= '0;
      hit_q       <= '0;
      miss_q      <= '0;
      accessed_q  <= 1'b0;
      congested_q <= 1'b0;
      busy_q      <= 1'b0;
      bytes_q     <= '0;
    end else begin
      retired_q   <= core_retired_i;
      load_q      <= core_load_i;
      fpu_q       <= core_fpu_issue_i;
      hit_q       <= icache_hit_i;
      miss_q      <= icache_miss_i;
      accessed_q  <= tcdm_accessed_i;
      congested_q <= tcdm_congested_i;
      busy_q      <= dma_busy_i;
      bytes_q     <= dma_bytes_i;
    end
  end

  for (genvar i = 0; i < NumPerfCounters; i++) begin : gen_cnt
    perf_metric_e            metric;
    logic [HartWidth-1:0]    hart;
    logic [CoreSelWidth-1:0] core;
    logic                    hart_ok;
    logic [CounterWidth-1:0] incr;
    logic [CounterWidth-1:0] cnt_q;

    assign metric  = perf_metric_e'(cnt_metric_i[i*MetricWidth +: MetricWidth]);
    assign hart    = cnt_hart_i[i*HartWidth +: HartWidth];
    assign core    = hart[CoreSelWidth-1:0];
    // Harts beyond the cluster see no per-core events.
    assign hart_ok = hart < HartWidth'(NrCores);

    always_comb begin
      case (metric)
        Cycle:         incr = CounterWidth'(1);
        TcdmAccessed:  incr = CounterWidth'(accessed_q);
        TcdmCongested: incr = CounterWidth'(congested_q);
        IssueFpu:      incr = CounterWidth'(hart_ok & fpu_q[core]);
        RetiredInstr:  incr = CounterWidth'(hart_ok & retired_q[core]);
        RetiredLoad:   incr = CounterWidth'(hart_ok & load_q[core]);
        DmaBusy:       incr = CounterWidth'(busy_q);
        DmaBytes:      incr = CounterWidth'(bytes_q);
        IcacheMiss:    incr = CounterWidth'(hart_ok & miss_q[core]);
        IcacheHit:     incr = CounterWidth'(hart_ok & hit_q[core]);
        default:       incr = '0;
      endcase
    end

    // A clear beats an increment in the same cycle.
    always_ff @(posedge clk_i) begin
      if (reset_i || cnt_clear_i[i]) begin
        cnt_q <= '0;
      end else if (cnt_en_i[i]) begin
        cnt_q <= cnt_q + incr;
      end
    end

    assign cnt_value_o[i*CounterWidth +: CounterWidth] = cnt_q;
  end

endmodule

//--- rtl/cluster_periph_top.sv
/* Top level of the cluster peripheral. The AXI4-Lite bridge drives the
   register file, which programs the counter bank and reads its values. */
`timescale 1ns/100ps

module cluster_periph_top #(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [cluster_periph_pkg::AddrWidth-1:0]   s_awaddr_i,
  input  logic                                       s_awvalid_i,
  output logic                                       s_awready_o,
  input  logic [cluster_periph_pkg::RegWidth-1:0]    s_wdata_i,
  input  logic [cluster_periph_pkg::RegWidth/8-1:0]  s_wstrb_i,
  input  logic                                       s_wvalid_i,
  output logic                                       s_wready_o,
  output logic [1:0]                                 s_bresp_o,
  output logic                                       s_bvalid_o,
  input  logic                                       s_bready_i,
  input  logic [cluster_periph_pkg::AddrWidth-1:0]   s_araddr_i,
  input  logic                                       s_arvalid_i,
  output logic                                       s_arready_o,
  output logic [cluster_periph_pkg::RegWidth-1:0]    s_rdata_o,
  output logic [1:0]                                 s_rresp_o,
  output logic                                       s_rvalid_o,
  input  logic                                       s_rready_i,
  input  logic [NrCores-1:0]                         core_retired_i,
  input  logic [NrCores-1:0]                         core_load_i,
  input  logic [NrCores-1:0]                         core_fpu_issue_i,
  input  logic                                       tcdm_accessed_i,
  input  logic                                       tcdm_congested_i,
  input  logic                                       dma_busy_i,
  input  logic [cluster_periph_pkg::DmaBytesWidth-1:0] dma_bytes_i,
  input  logic [NrCores-1:0]                         icache_hit_i,
  input  logic [NrCores-1:0]                         icache_miss_i,
  output logic                                       icache_prefetch_enable_o,
  output logic [NrCores-1:0]                         cl_clint_o
);
  import cluster_periph_pkg::*;

  logic                                    reg_wr, reg_rd, reg_err;
  logic [AddrWidth-1:0]                    reg_addr;
  logic [RegWidth-1:0]                     reg_wdata, reg_rdata;
  logic [RegWidth/8-1:0]                   reg_wstrb;
  logic [NumPerfCounters-1:0]              cnt_en, cnt_clear;
  logic [NumPerfCounters*MetricWidth-1:0]  cnt_metric;
  logic [NumPerfCounters*HartWidth-1:0]    cnt_hart;
  logic [NumPerfCounters*CounterWidth-1:0] cnt_value;

  axil_reg_bridge u_bridge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .reg_wr_o    (reg_wr),
    .reg_rd_o    (reg_rd),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_wstrb_o (reg_wstrb),
    .reg_rdata_i (reg_rdata),
    .reg_err_i   (reg_err)
  );

  periph_regfile #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) u_regfile (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .reg_wr_i                 (reg_wr),
    .reg_rd_i                 (reg_rd),
    .reg_addr_i               (reg_addr),
    .reg_wdata_i              (reg_wdata),
    .reg_wstrb_i              (reg_wstrb),
    .reg_rdata_o              (reg_rdata),
    .reg_err_o                (reg_err),
    .icache_prefetch_enable_o (icache_prefetch_enable_o),
    .cl_clint_o               (cl_clint_o),
    .cnt_en_o                 (cnt_en),
    .cnt_clear_o              (cnt_clear),
    .cnt_metric_o             (cnt_metric),
    .cnt_hart_o               (cnt_hart),
    .cnt_value_i              (cnt_value)
  );

  perf_counter_bank #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) u_counters (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cnt_en_i         (cnt_en),
    .cnt_clear_i      (cnt_clear),
    .cnt_metric_i     (cnt_metric),
    .cnt_hart_i       (cnt_hart),
    .core_retired_i   (core_retired_i),
    .core_load_i      (core_load_i),
    .core_fpu_issue_i (core_fpu_issue_i),
    .tcdm_accessed_i  (tcdm_accessed_i),
    .tcdm_congested_i (tcdm_congested_i),
    .dma_busy_i       (dma_busy_i),
    .dma_bytes_i      (dma_bytes_i),
    .icache_hit_i     (icache_hit_i),
    .icache_miss_i    (icache_miss_i),
    .cnt_value_o      (cnt_value)
  );

endmodule

//--- sim/tb_cluster_periph.sv
/* Self-checking testbench for the cluster peripheral. Drives the AXI4-Lite
   port and the event inputs, keeps a model of the registers and counts, and
   checks reads, outputs and the B/R hold rules with assertions. */
`timescale 1ns/100ps

module tb_cluster_periph;

  localparam int NrCores       = 4;
  localparam int NumCounters   = 4;
  // 0xFFFF per cycle needs just over 65536 cycles to pass 2^32.
  localparam int LongRunCycles = 65540;
  // The long DMA run dominates; the margin covers reset, bus traffic and short runs.
  localparam int TimeoutCycles = LongRunCycles + 6000;
  localparam logic [1:0] Okay   = 2'b00;
  localparam logic [1:0] SlvErr = 2'b10;

  logic               clk, reset;
  logic [11:0]        s_awaddr, s_araddr;
  logic               s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic               s_arvalid, s_arready, s_rvalid, s_rready;
  logic [31:0]        s_wdata, s_rdata;
  logic [3:0]         s_wstrb;
  logic [1:0]         s_bresp, s_rresp;
  logic [NrCores-1:0] core_retired, core_load, core_fpu_issue, icache_hit, icache_miss;
  logic               tcdm_accessed, tcdm_congested, dma_busy;
  logic [15:0]        dma_bytes;
  logic               prefetch_en;
  logic [NrCores-1:0] cl_clint;

  logic [31:0] lcg_state   = 32'hbb68ade2;
  int unsigned cycle_count = 0;
  logic        b_wait_q    = 1'b0;
  logic        r_wait_q    = 1'b0;
  logic [1:0]  bresp_q, rresp_q;
  logic [31:0] rdata_q;

  cluster_periph_top #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumCounters)
  ) u_dut (
    .clk_i                    (clk),
    .reset_i                  (reset),
    .s_awaddr_i               (s_awaddr),
    .s_awvalid_i              (s_awvalid),
    .s_awready_o              (s_awready),
    .s_wdata_i                (s_wdata),
    .s_wstrb_i                (s_wstrb),
    .s_wvalid_i               (s_wvalid),
    .s_wready_o               (s_wready),
    .s_bresp_o                (s_bresp),
    .s_bvalid_o               (s_bvalid),
    .s_bready_i               (s_bready),
    .s_araddr_i               (s_araddr),
    .s_arvalid_i              (s_arvalid),
    .s_arready_o              (s_arready),
    .s_rdata_o                (s_rdata),
    .s_rresp_o                (s_rresp),
    .s_rvalid_o               (s_rvalid),
    .s_rready_i               (s_rready),
    .core_retired_i           (core_retired),
    .core_load_i              (core_load),
    .core_fpu_issue_i         (core_fpu_issue),
    .tcdm_accessed_i          (tcdm_accessed),
    .tcdm_congested_i         (tcdm_congested),
    .dma_busy_i               (dma_busy),
    .dma_bytes_i              (dma_bytes),
    .icache_hit_i             (icache_hit),
    .icache_miss_i            (icache_miss),
    .icache_prefetch_enable_o (prefetch_en),
    .cl_clint_o               (cl_clint)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    abort_run();
  endtask

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else report_mismatch(name, expected, actual);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      report_failure($sformatf("timeout, run still busy after %0d cycles", cycle_count));
    end
  end

  // B and R must hold valid and payload until the handshake.
  always @(negedge clk) begin
    if (!reset) begin
      if (b_wait_q) begin
        assert (s_bvalid) else report_failure("bvalid dropped before it was accepted");
        assert (s_bresp === bresp_q) else report_mismatch("s_bresp_o", bresp_q, s_bresp);
      end
      if (r_wait_q) begin
        assert (s_rvalid) else report_failure("rvalid dropped before it was accepted");
        assert (s_rresp === rresp_q) else report_mismatch("s_rresp_o", rresp_q, s_rresp);
        assert (s_rdata === rdata_q) else report_mismatch("s_rdata_o", rdata_q, s_rdata);
      end
    end
    b_wait_q <= s_bvalid & ~s_bready;
    r_wait_q <= s_rvalid & ~s_rready;
    bresp_q  <= s_bresp;
    rresp_q  <= s_rresp;
    rdata_q  <= s_rdata;
  end

  // LCG with the low byte dropped, since its low bits cycle quickly.
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, lcg_state[31:8]};
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_events();
    core_retired   = '0;
    core_load      = '0;
    core_fpu_issue = '0;
    icache_hit     = '0;
    icache_miss    = '0;
    tcdm_accessed  = 1'b0;
    tcdm_congested = 1'b0;
    dma_busy       = 1'b0;
    dma_bytes      = '0;
  endtask

  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int unsigned min_wait,
                            output logic [1:0] resp);
    int unsigned wait_cycles;
    logic        aw_go, w_go;
    wait_cycles = min_wait + next_rand() % 4;
    s_awaddr  = addr;
    s_awvalid = 1'b1;
    s_wdata   = data;
    s_wstrb   = strb;
    s_wvalid  = 1'b1;
    while (s_awvalid || s_wvalid) begin
      aw_go = s_awvalid & s_awready;
      w_go  = s_wvalid & s_wready;
      step_cycle();
      if (aw_go) s_awvalid = 1'b0;
      if (w_go) s_wvalid = 1'b0;
    end
    while (!s_bvalid)
      step_cycle();
    repeat (wait_cycles) step_cycle();
    s_bready = 1'b1;
    resp     = s_bresp;
    step_cycle();
    s_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int unsigned wait_cycles;
    wait_cycles = next_rand() % 4;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    while (!s_arready)
      step_cycle();
    step_cycle();
    s_arvalid = 1'b0;
    while (!s_rvalid)
      step_cycle();
    repeat (wait_cycles) step_cycle();
    s_rready = 1'b1;
    data     = s_rdata;
    resp     = s_rresp;
    step_cycle();
    s_rready = 1'b0;
  endtask

  task automatic write_ok(input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic [1:0] resp;
    axil_write(addr, data, strb, 0, resp);
    check_equal($sformatf("s_bresp_o @ 0x%03h", addr), Okay, resp);
  endtask

  task automatic expect_read(input logic [11:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_equal($sformatf("s_rresp_o @ 0x%03h", addr), Okay, resp);
    check_equal($sformatf("s_rdata_o @ 0x%03h", addr), expected, data);
  endtask

  task automatic verify_reset_state();
    logic [4:0] reset_metric [NumCounters];
    // Cycle, RetiredInstr, TcdmAccessed, IcacheMiss.
    reset_metric = '{5'd0, 5'd4, 5'd1, 5'd8};
    check_equal("s_awready_o", 1, s_awready);
    check_equal("s_wready_o", 1, s_wready);
    check_equal("s_arready_o", 1, s_arready);
    check_equal("s_bvalid_o", 0, s_bvalid);
    check_equal("s_rvalid_o", 0, s_rvalid);
    check_equal("icache_prefetch_enable_o", 1, prefetch_en);
    check_equal("cl_clint_o", 0, cl_clint);
    expect_read(12'h000, 32'h0);
    for (int i = 0; i < NumCounters; i++) begin
      expect_read(12'(12'h040 + 4 * i), 32'(reset_metric[i]));
      expect_read(12'(12'h080 + 8 * i), 32'h0);
      expect_read(12'(12'h084 + 8 * i), 32'h0);
    end
  endtask

  task automatic exercise_wake_lines();
    logic [NrCores-1:0] model, mask;
    model = '0;
    for (int n = 0; n < 12; n++) begin
      mask = NrCores'(next_rand());
      if (next_rand() % 2 == 0) begin
        write_ok(12'h008, 32'(mask), 4'hF);
        model = model | mask;
      end else begin
        write_ok(12'h00C, 32'(mask), 4'hF);
        model = model & ~mask;
      end
      check_equal("cl_clint_o", model, cl_clint);
      expect_read(12'h008, 32'(model));
      expect_read(12'h00C, 32'(model));
    end
    // Only byte 0 holds the prefetch and enable bits.
    write_ok(12'h004, 32'h0, 4'b1110);
    check_equal("icache_prefetch_enable_o", 1, prefetch_en);
    write_ok(12'h004, 32'hFFFF_FF00, 4'b0001);
    check_equal("icache_prefetch_enable_o", 0, prefetch_en);
    expect_read(12'h004, 32'h0);
    write_ok(12'h004, 32'h1, 4'b0001);
    write_ok(12'h000, 32'h0000_000F, 4'b1110);
    expect_read(12'h000, 32'h0);
    write_ok(12'h000, 32'hFFFF_FF05, 4'b0001);
    expect_read(12'h000, 32'h5);
    write_ok(12'h000, 32'h0, 4'hF);
  endtask

  task automatic cycle_enable_and_clear();
    logic [31:0] first, second;
    logic [1:0]  resp;
    write_ok(12'h040, 32'd0, 4'hF);
    write_ok(12'h080, 32'h0, 4'hF);
    write_ok(12'h000, 32'h1, 4'hF);
    repeat (20) step_cycle();
    write_ok(12'h000, 32'h0, 4'hF);
    axil_read(12'h080, first, resp);
    check_equal("s_rresp_o @ 0x080", Okay, resp);
    axil_read(12'h080, second, resp);
    check_equal("s_rresp_o @ 0x080", Okay, resp);
    check_equal("s_rdata_o @ 0x080 on reread", first, second);
    assert (first != 0) else report_failure("Cycle counter stayed at zero while enabled");
    // A write to the high word clears the whole counter.
    write_ok(12'h084, 32'h0, 4'hF);
    expect_read(12'h080, 32'h0);
    expect_read(12'h084, 32'h0);
  endtask

  task automatic count_hart_events();
    logic [7:0]  hart_a, hart_b;
    logic [31:0] pattern;
    int unsigned retired_cnt, hit_cnt, access_cnt;
    hart_a = 8'(next_rand() % NrCores);
    hart_b = 8'(next_rand() % NrCores);
    write_ok(12'h040, {8'h0, hart_a, 11'h0, 5'd4}, 4'hF);
    write_ok(12'h044, {8'h0, hart_b, 11'h0, 5'd9}, 4'hF);
    write_ok(12'h048, {8'h0, 8'(next_rand() % NrCores), 11'h0, 5'd1}, 4'hF);
    write_ok(12'h04C, {8'h0, 8'd5, 11'h0, 5'd4}, 4'hF);
    for (int i = 0; i < NumCounters; i++) begin
      write_ok(12'(12'h080 + 8 * i), 32'h0, 4'hF);
    end
    write_ok(12'h000, 32'hF, 4'hF);
    retired_cnt = 0;
    hit_cnt     = 0;
    access_cnt  = 0;
    repeat (200) begin
      pattern        = next_rand();
      core_retired   = pattern[3:0];
      icache_hit     = pattern[7:4];
      core_load      = pattern[11:8];
      core_fpu_issue = pattern[15:12];
      icache_miss    = pattern[19:16];
      tcdm_congested = pattern[20];
      tcdm_accessed  = pattern[21];
      retired_cnt += core_retired[hart_a];
      hit_cnt     += icache_hit[hart_b];
      access_cnt  += tcdm_accessed;
      step_cycle();
    end
    clear_events();
    repeat (3) step_cycle();
    write_ok(12'h000, 32'h0, 4'hF);
    expect_read(12'h080, retired_cnt);
    expect_read(12'h088, hit_cnt);
    expect_read(12'h090, access_cnt);
    expect_read(12'h098, 32'h0);
    for (int i = 0; i < NumCounters; i++) begin
      expect_read(12'(12'h084 + 8 * i), 32'h0);
    end
  endtask

  task automatic sum_dma_bytes();
    logic [63:0] expected;
    write_ok(12'h040, 32'd7, 4'hF);
    write_ok(12'h080, 32'h0, 4'hF);
    write_ok(12'h000, 32'h1, 4'hF);
    expected = '0;
    repeat (100) begin
      dma_bytes = 16'(next_rand());
      expected  = expected + dma_bytes;
      step_cycle();
    end
    // All-ones byte counts, long enough to carry into the high word.
    dma_bytes = 16'hFFFF;
    repeat (LongRunCycles) begin
      expected = expected + 16'hFFFF;
      step_cycle();
    end
    dma_bytes = '0;
    repeat (3) step_cycle();
    write_ok(12'h000, 32'h0, 4'hF);
    expect_read(12'h080, expected[31:0]);
    expect_read(12'h084, 32'(expected[47:32]));
  endtask

  task automatic probe_errors();
    logic [11:0] bad_addr [2];
    logic [31:0] data;
    logic [1:0]  resp;
    bad_addr = '{12'h100, 12'h060};
    foreach (bad_addr[k]) begin
      axil_write(bad_addr[k], 32'hFFFF_FFFF, 4'hF, 0, resp);
      check_equal($sformatf("s_bresp_o @ 0x%03h", bad_addr[k]), SlvErr, resp);
      axil_read(bad_addr[k], data, resp);
      check_equal($sformatf("s_rresp_o @ 0x%03h", bad_addr[k]), SlvErr, resp);
      check_equal($sformatf("s_rdata_o @ 0x%03h", bad_addr[k]), 0, data);
    end
    // B held back for at least 10 cycles.
    axil_write(12'h004, 32'h0, 4'hF, 10, resp);
    check_equal("s_bresp_o @ 0x004", Okay, resp);
    check_equal("icache_prefetch_enable_o", 0, prefetch_en);
    expect_read(12'h004, 32'h0);
  endtask

  initial begin
    reset     = 1'b1;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    clear_events();
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    step_cycle();
    verify_reset_state();
    exercise_wake_lines();
    cycle_enable_and_clear();
    count_hart_events();
    sum_dma_bytes();
    probe_errors();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- verilog.f
rtl/cluster_periph_pkg.sv
rtl/axil_reg_bridge.sv
rtl/periph_regfile.sv
rtl/perf_counter_bank.sv
rtl/cluster_periph_top.sv
sim/tb_cluster_periph.sv
